// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator, runs it and looks for the pass line.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
	--top-module tb_wino_inverse -Mdir obj_dir -f tb.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/Vtb_wino_inverse)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation run returned status $status"
	exit 1
fi

if echo "$output" | grep -qx "Simulation passed"; then
	exit 0
fi
exit 1

// ==== source/wino_at_row.sv ====
`default_nettype none

`include "wino_defines.svh"

module wino_at_row #(
	parameter int ROW = 0
) (
	input  logic               clk,
	input  logic               i_rst,
	input  logic               i_valid,
	input  wino_pkg::acc_vec6_t i_vec,
	output logic               o_valid,
	output wino_pkg::acc_t      o_sum
);

	import wino_pkg::*;

	acc_t       term [`WINO_IN_ROWS];
	acc_t       pair [3];
	acc_t       mid [2];
	acc_t       sum;
	logic [2:0] valid_pipe;

	// Coefficients of the selected A^T row, all shifts and negations.
	always_comb begin
		for (int c = 0; c < `WINO_IN_ROWS; c++) begin
			term[c] = '0;
		end
		case (ROW)
			0: begin
				term[0] = i_vec[0];
				term[1] = i_vec[1];
				term[2] = i_vec[2];
				term[3] = i_vec[3];
				term[4] = i_vec[4];
			end
			1: begin
				term[1] = i_vec[1];
				term[2] = -i_vec[2];
				term[3] = i_vec[3] <<< 1;
				term[4] = -(i_vec[4] <<< 1);
			end
			2: begin
				term[1] = i_vec[1];
				term[2] = i_vec[2];
				term[3] = i_vec[3] <<< 2;
				term[4] = i_vec[4] <<< 2;
			end
			default: begin
				term[1] = i_vec[1];
				term[2] = -i_vec[2];
				term[3] = i_vec[3] <<< 3;
				term[4] = -(i_vec[4] <<< 3);
				term[5] = i_vec[5];
			end
		endcase
	end

	// Adder tree, pairs first, then the odd pair rides along one level.
	always_ff @(posedge clk) begin
		pair[0] <= term[0] + term[1];
		pair[1] <= term[2] + term[3];
		pair[2] <= term[4] + term[5];
		mid[0]  <= pair[0] + pair[1];
		mid[1]  <= pair[2];
		sum     <= mid[0] + mid[1];
	end

	always_ff @(posedge clk) begin
		if (i_rst) begin
			valid_pipe <= '0;
		end else begin
			valid_pipe <= {valid_pipe[1:0], i_valid};
		end
	end

	assign o_valid = valid_pipe[2];
	assign o_sum   = sum;

	// Fixed latency of three, as long as no reset fell inside the window.
	a_latency : assert property (@(posedge clk) disable iff (i_rst)
		(!$past(i_rst, 1) && !$past(i_rst, 2) && !$past(i_rst, 3))
		|-> (o_valid == $past(i_valid, 3)))
		else $error("o_valid does not follow i_valid by three cycles");

endmodule

`default_nettype wire

// ==== source/wino_defines.svh ====
`ifndef WINO_DEFINES_SVH
`define WINO_DEFINES_SVH

// Input tile is WINO_IN_ROWS by WINO_IN_ROWS values.
`define WINO_IN_ROWS 6

// Output tile is WINO_OUT_DIM by WINO_OUT_DIM pixels.
`define WINO_OUT_DIM 4

// Width of every transform word, sums wrap at this width.
`define WINO_ACC_W 30

// Output pixel width and the number of fraction bits dropped.
`define WINO_OUT_W 16
`define WINO_FRAC 8

`endif

// ==== source/wino_inverse_top.sv ====
`default_nettype none

`include "wino_defines.svh"

module wino_inverse_top (
	input  logic                clk,
	input  logic                i_rst,
	input  logic                i_valid,
	input  wino_pkg::acc_vec6_t i_row,
	output logic                o_ready,
	output logic                o_valid,
	output wino_pkg::pix_vec4_t o_pix
);

	import wino_pkg::*;

	logic      accept;
	logic      fp_valid;
	acc_vec4_t fp_beat;
	logic      rd_valid;
	acc_vec6_t rd_col;
	logic      sp_valid;
	acc_vec4_t sp_sum;

	assign accept = i_valid && o_ready;

	// First pass, beat r is row r of M*A. All rows share one valid.
	for (genvar i = 0; i < `WINO_OUT_DIM; i++) begin : g_first
		if (i == 0) begin : g_lead
			wino_at_row #(.ROW(i)) u_row (
				.clk     (clk),
				.i_rst   (i_rst),
				.i_valid (accept),
				.i_vec   (i_row),
				.o_valid (fp_valid),
				.o_sum   (fp_beat[i])
			);
		end else begin : g_rest
			wino_at_row #(.ROW(i)) u_row (
				.clk     (clk),
				.i_rst   (i_rst),
				.i_valid (accept),
				.i_vec   (i_row),
				.o_valid (),
				.o_sum   (fp_beat[i])
			);
		end
	end

	wino_tile_buffer u_buffer (
		.clk        (clk),
		.i_rst      (i_rst),
		.i_accept   (accept),
		.i_wr_valid (fp_valid),
		.i_wr_row   (fp_beat),
		.o_ready    (o_ready),
		.o_rd_valid (rd_valid),
		.o_rd_col   (rd_col)
	);

	// Second pass, drain beat j gives Y[0..3][j].
	for (genvar i = 0; i < `WINO_OUT_DIM; i++) begin : g_second
		if (i == 0) begin : g_lead
			wino_at_row #(.ROW(i)) u_row (
				.clk     (clk),
				.i_rst   (i_rst),
				.i_valid (rd_valid),
				.i_vec   (rd_col),
				.o_valid (sp_valid),
				.o_sum   (sp_sum[i])
			);
		end else begin : g_rest
			wino_at_row #(.ROW(i)) u_row (
				.clk     (clk),
				.i_rst   (i_rst),
				.i_valid (rd_valid),
				.i_vec   (rd_col),
				.o_valid (),
				.o_sum   (sp_sum[i])
			);
		end
	end

	wino_output_stage u_out (
		.clk     (clk),
		.i_rst   (i_rst),
		.i_valid (sp_valid),
		.i_sum   (sp_sum),
		.o_valid (o_valid),
		.o_pix   (o_pix)
	);

endmodule

`default_nettype wire

// ==== source/wino_output_stage.sv ====
`default_nettype none

`include "wino_defines.svh"

module wino_output_stage (
	input  logic                clk,
	input  logic                i_rst,
	input  logic                i_valid,
	input  wino_pkg::acc_vec4_t i_sum,
	output logic                o_valid,
	output wino_pkg::pix_vec4_t o_pix
);

	import wino_pkg::*;

	pix_t pix_next [`WINO_OUT_DIM];

	// ReLU, then keep the integer bits above the fraction.
	always_comb begin
		for (int i = 0; i < `WINO_OUT_DIM; i++) begin
			if (i_sum[i][`WINO_ACC_W-1]) begin
				pix_next[i] = '0;
			end else begin
				pix_next[i] = i_sum[i][`WINO_FRAC +: `WINO_OUT_W];
			end
		end
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < `WINO_OUT_DIM; i++) begin
			o_pix[i] <= pix_next[i];
		end
	end

	always_ff @(posedge clk) begin
		if (i_rst) begin
			o_valid <= 1'b0;
		end else begin
			o_valid <= i_valid;
		end
	end

endmodule

`default_nettype wire

// ==== source/wino_pkg.sv ====
`default_nettype none

`include "wino_defines.svh"

package wino_pkg;

	// One transform value, wraps modulo 2^WINO_ACC_W.
	typedef logic signed [`WINO_ACC_W-1:0] acc_t;

	// One unsigned output pixel.
	typedef logic [`WINO_OUT_W-1:0] pix_t;

	typedef acc_t acc_vec6_t [`WINO_IN_ROWS];
	typedef acc_t acc_vec4_t [`WINO_OUT_DIM];
	typedef pix_t pix_vec4_t [`WINO_OUT_DIM];

endpackage

`default_nettype wire

// ==== source/wino_tile_buffer.sv ====
`default_nettype none

`include "wino_defines.svh"

module wino_tile_buffer (
	input  logic                clk,
	input  logic                i_rst,
	input  logic                i_accept,
	input  logic                i_wr_valid,
	input  wino_pkg::acc_vec4_t i_wr_row,
	output logic                o_ready,
	output logic                o_rd_valid,
	output wino_pkg::acc_vec6_t o_rd_col
);

	import wino_pkg::*;

	localparam logic [3:0] BANK_ROWS = 4'(`WINO_IN_ROWS);
	localparam logic [3:0] CAPACITY  = 4'(2 * `WINO_IN_ROWS);

	// Two banks of first-pass results, row major.
	acc_t bank [2][`WINO_IN_ROWS][`WINO_OUT_DIM];

	logic [1:0] full;
	logic       wr_bank;
	logic [2:0] wr_row;
	logic       rd_bank;
	logic [2:0] rd_col;
	logic [2:0] in_flight;
	logic [3:0] held;
	logic       wr_last;
	logic       rd_last;

	assign wr_last = i_wr_valid && (wr_row == 3'(`WINO_IN_ROWS - 1));
	assign rd_last = o_rd_valid && (rd_col == 3'(`WINO_OUT_DIM - 1));

	// Rows committed to a bank, including those still in the first pass.
	always_comb begin
		held = {1'b0, wr_row} + {1'b0, in_flight};
		if (full[0]) begin
			held = held + BANK_ROWS;
		end
		if (full[1]) begin
			held = held + BANK_ROWS;
		end
	end

	assign o_ready = (held < CAPACITY);

	always_ff @(posedge clk) begin
		if (i_wr_valid) begin
			for (int c = 0; c < `WINO_OUT_DIM; c++) begin
				bank[wr_bank][wr_row][c] <= i_wr_row[c];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (i_rst) begin
			in_flight <= '0;
		end else begin
			in_flight <= in_flight + {2'b00, i_accept} - {2'b00, i_wr_valid};
		end
	end

	// Fill side.
	always_ff @(posedge clk) begin
		if (i_rst) begin
			wr_bank <= 1'b0;
			wr_row  <= '0;
		end else if (i_wr_valid) begin
			if (wr_last) begin
				wr_bank <= ~wr_bank;
				wr_row  <= '0;
			end else begin
				wr_row <= wr_row + 3'd1;
			end
		end
	end

	// Drain side, one column per cycle while the bank is full.
	always_ff @(posedge clk) begin
		if (i_rst) begin
			rd_bank <= 1'b0;
			rd_col  <= '0;
		end else if (o_rd_valid) begin
			if (rd_last) begin
				rd_bank <= ~rd_bank;
				rd_col  <= '0;
			end else begin
				rd_col <= rd_col + 3'd1;
			end
		end
	end

	// Set and clear never hit the same bank on one edge.
	always_ff @(posedge clk) begin
		if (i_rst) begin
			full <= '0;
		end else begin
			if (wr_last) begin
				full[wr_bank] <= 1'b1;
			end
			if (rd_last) begin
				full[rd_bank] <= 1'b0;
			end
		end
	end

	assign o_rd_valid = full[rd_bank];

	always_comb begin
		for (int r = 0; r < `WINO_IN_ROWS; r++) begin
			o_rd_col[r] = bank[rd_bank][r][rd_col[1:0]];
		end
	end

	a_no_overwrite : assert property (@(posedge clk) disable iff (i_rst)
		i_wr_valid |-> !full[wr_bank])
		else $error("first-pass row written into a full bank");

	a_col_range : assert property (@(posedge clk) disable iff (i_rst)
		rd_col < 3'(`WINO_OUT_DIM))
		else $error("drain column counter out of range");

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+source
source/wino_pkg.sv
source/wino_at_row.sv
source/wino_tile_buffer.sv
source/wino_output_stage.sv
source/wino_inverse_top.sv
verif/wino_checker.sv
verif/tb_wino_inverse.sv

// ==== verif/tb_wino_inverse.sv ====
`default_nettype none

`include "wino_defines.svh"

module tb_wino_inverse;

	timeunit 1ns;
	timeprecision 1ps;

	import wino_pkg::*;

	localparam int WAIT_LIMIT = 200;

	// Standard F(4,3) output transform, one row of A^T per entry.
	localparam int AT_COEF [4][6] = '{
		'{1, 1, 1, 1, 1, 0},
		'{0, 1, -1, 2, -2, 0},
		'{0, 1, 1, 4, 4, 0},
		'{0, 1, -1, 8, -8, 1}
	};

	logic      clk;
	logic      i_rst;
	logic      i_valid;
	acc_vec6_t i_row;
	logic      o_ready;
	logic      o_valid;
	pix_vec4_t o_pix;

	int   chk_errors;
	int   chk_checks;
	int   chk_pending;
	int   tests;
	int   err_base;
	logic timed_out;
	acc_t tile [`WINO_IN_ROWS][`WINO_IN_ROWS];

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	wino_inverse_top DUT (
		.clk     (clk),
		.i_rst   (i_rst),
		.i_valid (i_valid),
		.i_row   (i_row),
		.o_ready (o_ready),
		.o_valid (o_valid),
		.o_pix   (o_pix)
	);

	wino_checker u_checker (
		.clk        (clk),
		.i_rst      (i_rst),
		.i_in_valid (i_valid),
		.i_in_ready (o_ready),
		.i_valid    (o_valid),
		.i_pix      (o_pix),
		.o_errors   (chk_errors),
		.o_checks   (chk_checks),
		.o_pending  (chk_pending)
	);

	// Y = A^T * M * A with both passes wrapped to 30 bits, then ReLU and scaling.
	function automatic void wino_ref();
		acc_t                                 ma [`WINO_IN_ROWS][`WINO_OUT_DIM];
		longint                               sum;
		acc_t                                 val;
		logic [`WINO_OUT_DIM*`WINO_OUT_W-1:0] beat;
		for (int r = 0; r < `WINO_IN_ROWS; r++) begin
			for (int i = 0; i < `WINO_OUT_DIM; i++) begin
				sum = 0;
				for (int k = 0; k < `WINO_IN_ROWS; k++) begin
					sum += longint'(AT_COEF[i][k]) * longint'(tile[r][k]);
				end
				ma[r][i] = acc_t'(sum);
			end
		end
		for (int j = 0; j < `WINO_OUT_DIM; j++) begin
			beat = '0;
			for (int i = 0; i < `WINO_OUT_DIM; i++) begin
				sum = 0;
				for (int r = 0; r < `WINO_IN_ROWS; r++) begin
					sum += longint'(AT_COEF[i][r]) * longint'(ma[r][j]);
				end
				val = acc_t'(sum);
				if (!val[`WINO_ACC_W-1]) begin
					beat[i*`WINO_OUT_W +: `WINO_OUT_W] = val[`WINO_FRAC +: `WINO_OUT_W];
				end
			end
			u_checker.push_expected(beat);
		end
	endfunction

	function automatic void fill_random(input int lo, input int span);
		for (int r = 0; r < `WINO_IN_ROWS; r++) begin
			for (int c = 0; c < `WINO_IN_ROWS; c++) begin
				tile[r][c] = acc_t'(lo + int'($urandom % span));
			end
		end
	endfunction

	task automatic send_tile(input int gap_pct);
		int idle;
		int waited;
		for (int r = 0; r < `WINO_IN_ROWS; r++) begin
			if (!timed_out) begin
				idle = 0;
				if (int'($urandom % 100) < gap_pct) begin
					idle = 1 + int'($urandom % 3);
				end
				repeat (idle) begin
					i_valid <= 1'b0;
					@(posedge clk);
				end
				i_valid <= 1'b1;
				for (int c = 0; c < `WINO_IN_ROWS; c++) begin
					i_row[c] <= tile[r][c];
				end
				waited = 0;
				@(posedge clk);
				// Row is held until an edge sees o_ready high.
				while (!o_ready && !timed_out) begin
					waited++;
					if (waited > WAIT_LIMIT) begin
						$display("Timed out at %0d ns waiting for o_ready on row %0d", $time, r);
						timed_out = 1'b1;
					end else begin
						@(posedge clk);
					end
				end
			end
		end
	endtask

	task automatic run_tile(input int gap_pct);
		wino_ref();
		send_tile(gap_pct);
	endtask

	task automatic wait_drain();
		int waited;
		i_valid <= 1'b0;
		waited = 0;
		@(posedge clk);
		while (chk_pending != 0 && !timed_out) begin
			waited++;
			if (waited > WAIT_LIMIT) begin
				$display("Timed out at %0d ns with %0d output beats still missing",
					$time, chk_pending);
				timed_out = 1'b1;
			end else begin
				@(posedge clk);
			end
		end
		repeat (2) @(posedge clk);
	endtask

	task automatic finish_test(input string name);
		wait_drain();
		tests++;
		$display("test %0d (%s): %0d errors", tests, name, chk_errors - err_base);
		err_base = chk_errors;
	endtask

	initial begin
		void'($urandom(32'hd009a484));
		i_rst     = 1'b1;
		i_valid   = 1'b0;
		tests     = 0;
		err_base  = 0;
		timed_out = 1'b0;
		for (int c = 0; c < `WINO_IN_ROWS; c++) begin
			i_row[c] = '0;
		end
		repeat (10) @(posedge clk);
		i_rst <= 1'b0;

		// One product at [1][1] exposes column 1 of A^T in every output.
		for (int r = 0; r < `WINO_IN_ROWS; r++) begin
			for (int c = 0; c < `WINO_IN_ROWS; c++) begin
				tile[r][c] = '0;
			end
		end
		tile[1][1] = acc_t'(256);
		run_tile(0);
		finish_test("single tile, one nonzero product");

		for (int t = 0; t < 4 && !timed_out; t++) begin
			fill_random(-(1 << 20), (1 << 21) + 1);
			run_tile(0);
		end
		finish_test("random tiles back to back");

		for (int t = 0; t < 4 && !timed_out; t++) begin
			fill_random(-(1 << 20), (1 << 21) + 1);
			run_tile(40);
		end
		finish_test("random gaps in i_valid");

		for (int t = 0; t < 3 && !timed_out; t++) begin
			fill_random(-(1 << 26), (1 << 26) + (1 << 25));
			run_tile(0);
		end
		finish_test("negative-heavy wide tiles");

		// Latency and beat count are checked by the checker on every tile.
		for (int t = 0; t < 3 && !timed_out; t++) begin
			fill_random(-(1 << 22), (1 << 23) + 1);
			run_tile(30);
		end
		finish_test("latency and beat count");

		$display("tests run: %0d, checks: %0d, errors: %0d", tests, chk_checks, chk_errors);
		if (timed_out || chk_errors != 0) begin
			$display("Simulation failed");
		end else begin
			$display("Simulation passed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== verif/wino_checker.sv ====
`default_nettype none

`include "wino_defines.svh"

module wino_checker (
	input  logic                clk,
	input  logic                i_rst,
	input  logic                i_in_valid,
	input  logic                i_in_ready,
	input  logic                i_valid,
	input  wino_pkg::pix_vec4_t i_pix,
	output int                  o_errors,
	output int                  o_checks,
	output int                  o_pending
);

	timeunit 1ns;
	timeprecision 1ps;

	import wino_pkg::*;

	// Edges from the accept of a tile's sixth row to its first output beat.
	localparam int LATENCY = 8;

	// Edges from that accept to the edge that takes the tile's last drain column.
	localparam int BANK_HOLD = 3 + `WINO_OUT_DIM;

	logic [`WINO_OUT_DIM*`WINO_OUT_W-1:0] exp_q [$];
	int tile_done_q [$];
	// Last edge on which each complete tile still holds its bank.
	int hold_q [$];
	int cycle     = 0;
	int rows_in   = 0;
	int beat_idx  = 0;
	int last_beat = 0;
	int errors    = 0;
	int checks    = 0;

	// Called by the testbench with one expected output beat, pixel i in slice i.
	function automatic void push_expected(input logic [`WINO_OUT_DIM*`WINO_OUT_W-1:0] beat);
		exp_q.push_back(beat);
	endfunction

	// Input may stall only while both banks hold a tile, and must stall once both are full.
	task automatic check_ready();
		int banks;
		while (hold_q.size() != 0 && hold_q[0] < cycle) begin
			void'(hold_q.pop_front());
		end
		banks = hold_q.size() + ((rows_in != 0) ? 1 : 0);
		checks++;
		if (!i_in_ready && banks < 2) begin
			$display("** Error at %0d ns: o_ready expected 1, got 0", $time);
			errors++;
		end else if (i_in_ready && hold_q.size() >= 2) begin
			$display("** Error at %0d ns: o_ready expected 0, got 1", $time);
			errors++;
		end
	endtask

	task automatic check_beat();
		logic [`WINO_OUT_DIM*`WINO_OUT_W-1:0] want;
		int lat;
		if (exp_q.size() == 0) begin
			$display("o_valid went high at %0d ns with no output beat expected", $time);
			errors++;
		end else begin
			want = exp_q.pop_front();
			for (int i = 0; i < `WINO_OUT_DIM; i++) begin
				checks++;
				if (i_pix[i] !== want[i*`WINO_OUT_W +: `WINO_OUT_W]) begin
					$display("** Error at %0d ns: o_pix[%0d] expected %h, got %h",
						$time, i, want[i*`WINO_OUT_W +: `WINO_OUT_W], i_pix[i]);
					errors++;
				end
			end
			// First beat of a tile carries the latency check.
			if (beat_idx == 0) begin
				if (tile_done_q.size() == 0) begin
					$display("Output tile at %0d ns started before its input was complete",
						$time);
					errors++;
				end else begin
					lat = cycle - tile_done_q.pop_front();
					checks++;
					if (lat != LATENCY) begin
						$display("** Error at %0d ns: o_valid latency expected %0d, got %0d",
							$time, LATENCY, lat);
						errors++;
					end
				end
			end else if (cycle != last_beat + 1) begin
				$display("o_valid dropped inside the beats of one tile at %0d ns", $time);
				errors++;
			end
			last_beat = cycle;
			beat_idx  = (beat_idx + 1) % `WINO_OUT_DIM;
		end
	endtask

	always @(posedge clk) begin
		cycle = cycle + 1;
		if (i_rst) begin
			rows_in  = 0;
			beat_idx = 0;
			hold_q.delete();
		end else begin
			check_ready();
			if (i_in_valid && i_in_ready) begin
				if (rows_in == `WINO_IN_ROWS - 1) begin
					tile_done_q.push_back(cycle);
					hold_q.push_back(cycle + BANK_HOLD);
					rows_in = 0;
				end else begin
					rows_in = rows_in + 1;
				end
			end
			if (i_valid) begin
				check_beat();
			end
		end
		o_errors  <= errors;
		o_checks  <= checks;
		o_pending <= exp_q.size();
	end

endmodule

`default_nettype wire
